// ==== Makefile ====
TOP = dem_uart_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== sim.f ====
+incdir+source
source/dem_uart_pkg.sv
source/dem_uart_rx_buffer.sv
source/dem_uart_regs.sv
source/dem_uart_tx_packer.sv
source/dem_uart_top.sv
testbench/tb_clock.sv
testbench/dem_uart_asserts.sv
testbench/dem_uart_tb.sv

// ==== source/dem_uart_macros.svh ====
`ifndef DEM_UART_MACROS_SVH
`define DEM_UART_MACROS_SVH

////////////////////////////////////////////////////////////
// Queue sizing
////////////////////////////////////////////////////////////

// Entries per character queue
`define DEM_UART_FIFO_DEPTH 4

// Pointer width for the queues
`define DEM_UART_FIFO_AW 2

////////////////////////////////////////////////////////////
// Flit format
////////////////////////////////////////////////////////////

// Kind byte on top, character below
`define DEM_UART_FLIT_W 16

`endif

// ==== source/dem_uart_pkg.sv ====
package dem_uart_pkg;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // 16550 offsets, DLL/DLM share 0 and 1 when DLAB is set
  typedef enum logic [2:0] {
    REG_RBR_THR = 3'd0,
    REG_IER     = 3'd1,
    REG_IIR_FCR = 3'd2,
    REG_LCR     = 3'd3,
    REG_LSR     = 3'd5
  } uart_reg_e;

  // IIR low nibble, bit 0 set means nothing pending
  typedef enum logic [3:0] {
    INTR_NONE = 4'h1,
    INTR_TBE  = 4'h2,
    INTR_RBF  = 4'h4,
    INTR_LS   = 4'h6
  } iir_code_e;

  // Upper byte of a debug flit
  typedef enum logic [7:0] {
    FLIT_CHAR = 8'h01,
    FLIT_CTRL = 8'h02
  } flit_kind_e;

endpackage

// ==== source/dem_uart_regs.sv ====
`timescale 1ns/1ps

module dem_uart_regs import dem_uart_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       bus_req,
  input  logic [2:0] bus_addr,
  input  logic       bus_write,
  input  logic [7:0] bus_wdata,
  input  logic       in_valid,
  input  logic [7:0] in_char,
  input  logic       out_ready,
  output logic       bus_ack,
  output logic [7:0] bus_rdata,
  output logic       out_valid,
  output logic [7:0] out_char,
  output logic       in_ready,
  output logic       rx_clear,
  output logic       tx_clear,
  output logic       irq
);

  // LSR bit positions
  localparam int LSR_DR   = 0;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  // Line control, bit 7 is DLAB
  logic [7:0]  lcr, nxt_lcr;
  // Stored only, no baud generator behind it
  logic [15:0] divisor, nxt_divisor;

  // IER bits
  logic erbfi, etbei, elsi;
  logic nxt_erbfi, nxt_etbei, nxt_elsi;

  // FCR state
  logic fifo_enable, fifo_rx_clear, fifo_tx_clear;
  logic nxt_fifo_enable, nxt_fifo_rx_clear, nxt_fifo_tx_clear;

  logic      dlab;
  logic      irq_rbf;
  logic      irq_tbe;
  iir_code_e iir_code;
  uart_reg_e reg_sel;

  ////////////////////////////////////////////////////////////
  // Interrupts
  ////////////////////////////////////////////////////////////

  // Data waiting / room to send
  assign irq_rbf = erbfi & in_valid;
  assign irq_tbe = etbei & out_ready;
  assign irq     = irq_rbf | irq_tbe;

  // Receive outranks transmit
  always_comb begin
    if (irq_rbf) iir_code = INTR_RBF;
    else if (irq_tbe) iir_code = INTR_TBE;
    else iir_code = INTR_NONE;
  end

  // Flush pulses, one cycle after the FCR write
  assign rx_clear = fifo_enable & fifo_rx_clear;
  assign tx_clear = fifo_enable & fifo_tx_clear;

  assign dlab    = lcr[7];
  assign bus_ack = bus_req;
  assign reg_sel = uart_reg_e'(bus_addr);

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      lcr           <= '0;
      divisor       <= '0;
      erbfi         <= 1'b0;
      etbei         <= 1'b0;
      elsi          <= 1'b0;
      fifo_enable   <= 1'b0;
      fifo_rx_clear <= 1'b0;
      fifo_tx_clear <= 1'b0;
    end else begin
      lcr           <= nxt_lcr;
      divisor       <= nxt_divisor;
      erbfi         <= nxt_erbfi;
      etbei         <= nxt_etbei;
      elsi          <= nxt_elsi;
      fifo_enable   <= nxt_fifo_enable;
      fifo_rx_clear <= nxt_fifo_rx_clear;
      fifo_tx_clear <= nxt_fifo_tx_clear;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    nxt_lcr     = lcr;
    nxt_divisor = divisor;
    nxt_erbfi   = erbfi;
    nxt_etbei   = etbei;
    nxt_elsi    = elsi;
    nxt_fifo_enable = fifo_enable;
    // Clear bits self-clear unless rewritten
    nxt_fifo_rx_clear = 1'b0;
    nxt_fifo_tx_clear = 1'b0;
    out_valid = 1'b0;
    out_char  = 8'h00;
    in_ready  = 1'b0;
    bus_rdata = 8'h00;

    if (bus_req) begin
      case (reg_sel)
        REG_RBR_THR: begin
          if (dlab) begin
            // DLL
            if (bus_write) nxt_divisor[7:0] = bus_wdata;
            else bus_rdata = divisor[7:0];
          end else if (bus_write) begin
            // THR, lost if packer not ready
            out_valid = 1'b1;
            out_char  = bus_wdata;
          end else begin
            // RBR read pops the head
            bus_rdata = in_char;
            in_ready  = 1'b1;
          end
        end
        REG_IER: begin
          if (dlab) begin
            // DLM
            if (bus_write) nxt_divisor[15:8] = bus_wdata;
            else bus_rdata = divisor[15:8];
          end else if (bus_write) begin
            {nxt_elsi, nxt_etbei, nxt_erbfi} = bus_wdata[2:0];
          end else begin
            bus_rdata = {5'b00000, elsi, etbei, erbfi};
          end
        end
        REG_IIR_FCR: begin
          if (bus_write) begin
            // FCR, DMA select ignored
            {nxt_fifo_tx_clear, nxt_fifo_rx_clear, nxt_fifo_enable} = bus_wdata[2:0];
          end else begin
            bus_rdata = {fifo_enable, fifo_enable, 2'b00, iir_code};
          end
        end
        REG_LCR: begin
          if (bus_write) nxt_lcr = bus_wdata;
          else bus_rdata = lcr;
        end
        REG_LSR: begin
          // Read only, writes fall through
          bus_rdata[LSR_DR]   = in_valid;
          bus_rdata[LSR_THRE] = out_ready;
          bus_rdata[LSR_TEMT] = out_ready;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== source/dem_uart_rx_buffer.sv ====
`timescale 1ns/1ps
`include "dem_uart_macros.svh"

module dem_uart_rx_buffer import dem_uart_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flit_in_valid,
  input  logic [`DEM_UART_FLIT_W-1:0] flit_in_data,
  input  logic                        in_ready,
  input  logic                        rx_clear,
  output logic                        in_valid,
  output logic [7:0]                  in_char
);

  // Character storage
  logic [7:0] mem [`DEM_UART_FIFO_DEPTH];

  logic [`DEM_UART_FIFO_AW-1:0] rd_ptr;
  logic [`DEM_UART_FIFO_AW-1:0] wr_ptr;
  logic [`DEM_UART_FIFO_AW:0]   count;

  flit_kind_e kind;
  logic       full;
  logic       push;
  logic       pop;

  ////////////////////////////////////////////////////////////
  // Flit filter
  ////////////////////////////////////////////////////////////

  // Kind lives in the top byte
  assign kind = flit_kind_e'(flit_in_data[`DEM_UART_FLIT_W-1 -: 8]);
  assign full = (count == (`DEM_UART_FIFO_AW+1)'(`DEM_UART_FIFO_DEPTH));

  // Control flits and overflow characters are dropped
  assign push = flit_in_valid && (kind == FLIT_CHAR) && !full;
  // RBR read on empty queue does nothing
  assign pop  = in_ready && (count != '0);

  ////////////////////////////////////////////////////////////
  // Queue
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= flit_in_data[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || rx_clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // Push and pop together leave count alone
      count <= count + {{`DEM_UART_FIFO_AW{1'b0}}, push} - {{`DEM_UART_FIFO_AW{1'b0}}, pop};
    end
  end

  // Head of queue towards the register block
  assign in_valid = (count != '0);
  assign in_char  = mem[rd_ptr];

endmodule

// ==== source/dem_uart_top.sv ====
`timescale 1ns/1ps
`include "dem_uart_macros.svh"

module dem_uart_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        bus_req,
  input  logic [2:0]                  bus_addr,
  input  logic                        bus_write,
  input  logic [7:0]                  bus_wdata,
  output logic                        bus_ack,
  output logic [7:0]                  bus_rdata,
  input  logic                        flit_in_valid,
  input  logic [`DEM_UART_FLIT_W-1:0] flit_in_data,
  output logic                        flit_out_valid,
  output logic [`DEM_UART_FLIT_W-1:0] flit_out_data,
  input  logic                        flit_out_ready,
  input  logic                        drop,
  output logic                        irq
);

  // Receive path
  logic       in_valid, in_ready;
  logic [7:0] in_char;
  // Transmit path
  logic       out_valid, out_ready;
  logic [7:0] out_char;
  // FCR flushes
  logic       rx_clear, tx_clear;

  dem_uart_rx_buffer u_rx (.clk, .rst, .flit_in_valid, .flit_in_data,
                           .in_ready, .rx_clear, .in_valid, .in_char);

  dem_uart_regs u_regs (.clk, .rst, .bus_req, .bus_addr, .bus_write, .bus_wdata,
                        .in_valid, .in_char, .out_ready, .bus_ack, .bus_rdata,
                        .out_valid, .out_char, .in_ready, .rx_clear, .tx_clear, .irq);

  dem_uart_tx_packer u_tx (.clk, .rst, .out_valid, .out_char, .drop, .tx_clear,
                           .flit_out_ready, .out_ready, .flit_out_valid,
                           .flit_out_data);

endmodule

// ==== source/dem_uart_tx_packer.sv ====
`timescale 1ns/1ps
`include "dem_uart_macros.svh"

module dem_uart_tx_packer import dem_uart_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        out_valid,
  input  logic [7:0]                  out_char,
  input  logic                        drop,
  input  logic                        tx_clear,
  input  logic                        flit_out_ready,
  output logic                        out_ready,
  output logic                        flit_out_valid,
  output logic [`DEM_UART_FLIT_W-1:0] flit_out_data
);

  // Outgoing characters, payload only
  logic [7:0] mem [`DEM_UART_FIFO_DEPTH];

  logic [`DEM_UART_FIFO_AW-1:0] rd_ptr;
  logic [`DEM_UART_FIFO_AW-1:0] wr_ptr;
  logic [`DEM_UART_FIFO_AW:0]   count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign full  = (count == (`DEM_UART_FIFO_AW+1)'(`DEM_UART_FIFO_DEPTH));
  assign empty = (count == '0);

  // Host discard makes the sink always ready
  assign out_ready = drop | !full;
  // Nothing gets queued while dropping
  assign push = out_valid && !drop && !full;
  // Drop drains one entry per cycle with no flit shown
  assign pop  = !empty && (drop || flit_out_ready);

  assign flit_out_valid = !empty && !drop;
  assign flit_out_data  = {FLIT_CHAR, mem[rd_ptr]};

  ////////////////////////////////////////////////////////////
  // Queue
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= out_char;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || tx_clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{`DEM_UART_FIFO_AW{1'b0}}, push} - {{`DEM_UART_FIFO_AW{1'b0}}, pop};
    end
  end

endmodule

// ==== testbench/dem_uart_asserts.sv ====
`timescale 1ns/1ps
`include "dem_uart_macros.svh"

module dem_uart_asserts (
  input logic                        clk,
  input logic                        rst,
  input logic                        bus_req,
  input logic                        bus_ack,
  input logic                        flit_out_valid,
  input logic [`DEM_UART_FLIT_W-1:0] flit_out_data,
  input logic                        flit_out_ready,
  input logic                        drop,
  input logic                        irq,
  input logic                        in_valid,
  input logic                        out_ready,
  input logic                        rx_clear,
  input logic                        tx_clear
);

  // Ack comes back in the request cycle
  ack_follows_req: assert property (@(posedge clk) bus_ack == bus_req)
    else $error("bus_ack differs from bus_req");

  // Flit held until taken, unless flushed or dropped
  flit_held: assert property (@(posedge clk) disable iff (rst)
    flit_out_valid && !flit_out_ready && !tx_clear |=>
      drop || (flit_out_valid && $stable(flit_out_data)))
    else $error("flit_out_valid or flit_out_data changed before the transfer");

  // Quiet outputs once reset has been seen
  reset_quiet: assert property (@(posedge clk)
    $past(rst) |-> !flit_out_valid && !irq && !rx_clear && !tx_clear)
    else $error("outputs active during reset");

  // Irq needs a pending source
  irq_source: assert property (@(posedge clk) disable iff (rst)
    irq |-> (in_valid || out_ready))
    else $error("irq high with no pending source");

endmodule

bind dem_uart_top dem_uart_asserts u_asserts (
  .clk, .rst, .bus_req, .bus_ack, .flit_out_valid, .flit_out_data, .flit_out_ready,
  .drop, .irq, .in_valid, .out_ready, .rx_clear, .tx_clear
);

// ==== testbench/dem_uart_tb.sv ====
`timescale 1ns/1ps
`include "dem_uart_macros.svh"

module dem_uart_tb import dem_uart_pkg::*; ();

  localparam int    CYCLE_NS    = 20;
  localparam int    LINE_CYCLES = 200;
  localparam int    FLIT_WAIT   = 40;
  localparam string TEST_FILE   = "testbench/dem_uart_tests.txt";

  logic                        clk, rst;
  logic                        bus_req, bus_write, bus_ack;
  logic [2:0]                  bus_addr;
  logic [7:0]                  bus_wdata, bus_rdata;
  logic                        flit_in_valid;
  logic [`DEM_UART_FLIT_W-1:0] flit_in_data;
  logic                        flit_out_valid;
  logic [`DEM_UART_FLIT_W-1:0] flit_out_data;
  logic                        flit_out_ready;
  logic                        drop, irq;

  // Ready level restored after an E operation
  logic   ready_level;
  integer seed = 32'h670b4693;
  int     errors = 0;
  int     test_errors = 0;
  int     tests = 0;
  int     line_count = 0;

  tb_clock u_clock (.clk, .rst);

  dem_uart_top dut0 (.*);

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      count_error();
    end
  endtask

  task automatic check_iir(input iir_code_e got, input iir_code_e exp);
    if (got !== exp) begin
      $display("error IIR[3:0] got %h expected %h", got, exp);
      count_error();
    end
  endtask

  task automatic check_flit(input flit_kind_e got_kind, input logic [7:0] got_char,
                            input flit_kind_e exp_kind, input logic [7:0] exp_char);
    if (got_kind !== exp_kind || got_char !== exp_char) begin
      $display("error flit_out_data got %h expected %h",
               {got_kind, got_char}, {exp_kind, exp_char});
      count_error();
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error irq got %h expected %h", got, exp);
      count_error();
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error flit_out_valid got %h expected %h", got, exp);
      count_error();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic bus_op(input logic wr, input logic [2:0] addr, input logic [7:0] data,
                        output logic [7:0] rdata);
    bus_req   = 1'b1;
    bus_write = wr;
    bus_addr  = addr;
    bus_wdata = data;
    // Read data settles well before the falling edge
    @(negedge clk);
    rdata = bus_rdata;
    next_cycle();
    bus_req   = 1'b0;
    bus_write = 1'b0;
  endtask

  task automatic send_flit(input logic [7:0] kind, input logic [7:0] ch);
    flit_in_valid = 1'b1;
    flit_in_data  = {kind, ch};
    next_cycle();
    flit_in_valid = 1'b0;
  endtask

  // Pull one flit with ready, bounded wait
  task automatic expect_flit(input flit_kind_e exp_kind, input logic [7:0] exp_char);
    logic                        got;
    logic [`DEM_UART_FLIT_W-1:0] data;
    int                          i;
    got = 1'b0;
    data = '0;
    flit_out_ready = 1'b1;
    for (i = 0; i < FLIT_WAIT && !got; i++) begin
      @(negedge clk);
      if (flit_out_valid) begin
        got  = 1'b1;
        data = flit_out_data;
      end
      next_cycle();
    end
    flit_out_ready = ready_level;
    if (!got) begin
      $display("no flit arrived on flit_out within %0d cycles", FLIT_WAIT);
      count_error();
    end else begin
      check_flit(flit_kind_e'(data[15:8]), data[7:0], exp_kind, exp_char);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequencer
  ////////////////////////////////////////////////////////////

  initial begin : run
    int               fd;
    int               n;
    int               idle;
    logic [7:0]       op, a, b, rd;
    logic [8*32-1:0]  name;
    logic [8*128-1:0] text;
    bus_req        = 1'b0;
    bus_write      = 1'b0;
    bus_addr       = 3'd0;
    bus_wdata      = 8'h00;
    flit_in_valid  = 1'b0;
    flit_in_data   = '0;
    flit_out_ready = 1'b0;
    drop           = 1'b0;
    ready_level    = 1'b0;
    // First pass only counts lines for the watchdog
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the test file %s", TEST_FILE);
      $display("Verification failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(text, fd) > 0) line_count++;
      end
      $fclose(fd);
      fd = $fopen(TEST_FILE, "r");
      @(negedge rst);
      next_cycle();
      while ($fscanf(fd, " %c", op) == 1) begin
        case (op)
          "#": n = $fgets(text, fd);
          "W": begin
            n = $fscanf(fd, "%h %h", a, b);
            bus_op(1'b1, a[2:0], b, rd);
          end
          "R": begin
            n = $fscanf(fd, "%h %h", a, b);
            bus_op(1'b0, a[2:0], 8'h00, rd);
            // IIR code checked by type, FIFO bits separately
            if (a[2:0] == REG_IIR_FCR) begin
              check_iir(iir_code_e'(rd[3:0]), iir_code_e'(b[3:0]));
              check_byte("IIR[7:4]", {rd[7:4], 4'h0}, {b[7:4], 4'h0});
            end else begin
              check_byte("bus_rdata", rd, b);
            end
          end
          "F": begin
            n = $fscanf(fd, "%h %h", a, b);
            send_flit(a, b);
          end
          "E": begin
            n = $fscanf(fd, "%h %h", a, b);
            expect_flit(flit_kind_e'(a), b);
          end
          "Q": begin
            n = $fscanf(fd, "%h", a);
            ready_level    = a[0];
            flit_out_ready = a[0];
          end
          "D": begin
            n = $fscanf(fd, "%h", a);
            drop = a[0];
          end
          "I": begin
            n = $fscanf(fd, "%h", a);
            @(negedge clk);
            check_irq(irq, a[0]);
            next_cycle();
          end
          "V": begin
            n = $fscanf(fd, "%h", a);
            @(negedge clk);
            check_valid(flit_out_valid, a[0]);
            next_cycle();
          end
          "T": begin
            n = $fscanf(fd, "%s", name);
            tests++;
            $display("test %0s: %0s with %0d errors", name,
                     (test_errors == 0) ? "ok" : "FAILED", test_errors);
            test_errors = 0;
          end
          default: begin
            $display("unknown operation %c in the test file", op);
            count_error();
          end
        endcase
        // Every operation carries at least one operand
        if (n < 1) begin
          $display("operands missing for operation %c in the test file", op);
          count_error();
        end
        // Idle gap of 1 to 3 cycles between operations
        idle = 1 + ($unsigned($random(seed)) % 3);
        repeat (idle) next_cycle();
      end
      $fclose(fd);
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

  // Limit scales with the test file length
  initial begin : watchdog
    // Line count is complete once reset is released
    @(negedge rst);
    #(line_count * LINE_CYCLES * CYCLE_NS);
    $display("watchdog expired, the tests did not finish in %0d cycles",
             line_count * LINE_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== testbench/dem_uart_tests.txt ====
# op operands in hex: W addr data | R addr expect | F kind char | E kind char
# Q ready | D drop | I irq | V flit_out_valid | T test name
R 1 00
R 3 00
R 2 01
R 5 60
V 0
I 0
T reset
W 3 80
W 0 34
W 1 12
R 0 34
R 1 12
W 3 03
R 1 00
T divisor
Q 0
W 0 41
W 0 42
W 0 43
W 0 44
R 5 00
W 0 45
E 01 41
E 01 42
E 01 43
E 01 44
V 0
T transmit
F 02 99
F 01 61
F 01 62
F 01 63
F 01 64
F 01 65
R 5 61
R 0 61
R 0 62
R 0 63
R 0 64
R 5 60
T receive
W 1 03
R 2 02
F 01 70
R 2 04
I 1
R 0 70
W 1 01
I 0
R 2 01
W 1 00
T interrupts
F 01 11
W 0 33
R 5 61
W 2 07
R 5 60
R 2 c1
D 1
W 0 55
D 0
W 0 77
E 01 77
V 0
T flush_drop

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  // Free running clock
  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // Reset released just after an edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule
